/* dv/tb_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

        localparam int N_WR = 24;       // Writes in the lane test.
        localparam int N_AB = 8;
        localparam int MAX_TRY = 32;    // Attempts before a grant is given up.
        localparam int TEST_CYCLES = 65 + 2 * N_WR * MAX_TRY + N_WR + 4 +
                                     N_AB * (4 * MAX_TRY + 4);
        localparam longint WATCHDOG_NS = (2048 + 3 + TEST_CYCLES + 100) * 20;

        typedef struct packed
        {
                logic           abort;
                logic           miss;
                logic           abort1;
                logic           hit1;
                logic           wr_ok;
                logic [31:0]    data;
                logic [31:0]    data1;
        } expect_t;

        logic           i_clk = 1'b0;
        logic           i_rst_n = 1'b0;
        logic [31:0]    i_address = '0;
        logic [31:0]    i_address1 = '0;
        logic [31:0]    i_data = '0;
        logic [3:0]     i_ben = '0;
        logic           i_cpsr = 1'b0;
        logic           i_rd_en = 1'b0;
        logic           i_wr_en = 1'b0;
        logic [31:0]    o_data;
        logic [31:0]    o_data1;
        logic           o_miss;
        logic           o_hit1;
        logic           o_abort;
        logic           o_abort1;

        logic [7:0]                     ref_mem [mem_pkg::MEM_BYTES];
        logic [access_pkg::LFSR_W-1:0]  ref_lfsr = access_pkg::LFSR_SEED;
        logic [31:0]                    rnd_state = 32'he4ea8f10;
        logic [31:0]                    wr_addr [N_WR];
        expect_t                        pend;           // Expected outputs of the last request.
        logic                           pend_last = 1'b0;
        int                             pend_test = 0;
        string                          pend_name;
        int                             cur_test = 0;
        string                          cur_name;
        int                             n_driven = 0;
        int                             n_compared = 0;
        int                             err_count = 0;
        int                             test_err = 0;

        cache_top DUT (.*);

        initial
        begin
                forever #10 i_clk = ~i_clk;
        end

        initial
        begin
                #(WATCHDOG_NS);
                $display("Watchdog expired at %0t, the tests did not finish in time", $time);
                $display("TESTBENCH FAILED");
                $finish;
        end

        // Fibonacci LFSR with taps 32 22 2 1.
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                logic fb;
                v = '0;
                for (int k = 0; k < n; k++)
                begin
                        fb = rnd_state[31] ^ rnd_state[21] ^ rnd_state[1] ^ rnd_state[0];
                        rnd_state = {rnd_state[30:0], fb};
                        v = {v[30:0], fb};
                end
                return v;
        endfunction

        // Address above the protected region with its last byte inside memory.
        function automatic logic [31:0] rand_data_addr();
                return 32'(access_pkg::PROT_LIMIT) + rand_bits(13) %
                       32'(mem_pkg::MEM_BYTES - 3 - access_pkg::PROT_LIMIT);
        endfunction

        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                if (s[0])
                        return (s >> 1) ^ access_pkg::LFSR_TAPS;
                return s >> 1;
        endfunction

        // Byte as memory holds it once a granted write has landed.
        function automatic logic [7:0] merged_byte(input logic [31:0] a, input logic wen,
                        input logic [31:0] wa, input logic [3:0] ben, input logic [31:0] wd);
                logic [31:0] off;
                off = a - wa;
                if (wen && a >= wa && off < 4 && ben[off[1:0]])
                        return wd[8*off[1:0] +: 8];
                return ref_mem[a[12:0]];
        endfunction

        function automatic expect_t ref_result(input logic rd, input logic wr,
                        input logic [31:0] addr, input logic [31:0] addr1, input logic [31:0] data,
                        input logic [3:0] ben, input logic cpsr, input logic [15:0] lfsr);
                expect_t r;
                logic grant;
                r = '0;
                r.abort = (rd || wr) && (addr > 32'(mem_pkg::MEM_BYTES - 4) ||
                          (cpsr == access_pkg::MODE_USER && addr < 32'(access_pkg::PROT_LIMIT)));
                r.miss = !r.abort && lfsr[access_pkg::MISS_BIT];
                grant = (rd || wr) && !r.abort && !r.miss;
                r.wr_ok = grant && wr;
                r.abort1 = addr1 > 32'(mem_pkg::MEM_BYTES - 4);
                r.hit1 = !r.abort1 && lfsr[access_pkg::HIT_BIT];
                for (int n = 0; n < 4; n++)
                begin
                        if (grant)
                                r.data[8*n +: 8] = merged_byte(addr + n, r.wr_ok, addr, ben,
                                                               data);
                        if (r.hit1)
                                r.data1[8*n +: 8] = merged_byte(addr1 + n, r.wr_ok, addr, ben,
                                                                data);
                end
                return r;
        endfunction

        task automatic note_failure(input string what);
                $display("Error at %0t: %s", $time, what);
                err_count++;
                test_err++;
        endtask

        task automatic check_value(input string name, input logic [31:0] exp,
                        input logic [31:0] act);
                assert (act === exp)
                else
                begin
                        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
                        err_count++;
                        test_err++;
                end
        endtask

        // Drives one request after the edge and tracks it in the model.
        task automatic run_cycle(input logic rd, input logic wr, input logic [31:0] addr,
                        input logic [31:0] addr1, input logic [31:0] data, input logic [3:0] ben,
                        input logic cpsr, input logic last, output logic granted);
                expect_t e;
                #2;
                i_rd_en = rd;
                i_wr_en = wr;
                i_address = addr;
                i_address1 = addr1;
                i_data = data;
                i_ben = ben;
                i_cpsr = cpsr;
                e = ref_result(rd, wr, addr, addr1, data, ben, cpsr, ref_lfsr);
                pend = e;
                pend_last = last;
                pend_test = cur_test;
                pend_name = cur_name;
                n_driven++;
                granted = (rd || wr) && !e.abort && !e.miss;
                for (int n = 0; n < 4; n++)
                begin
                        if (e.wr_ok && ben[n])
                                ref_mem[addr + n] = data[8*n +: 8];
                end
                ref_lfsr = lfsr_next(ref_lfsr);
                @(posedge i_clk);
        endtask

        task automatic access_until_granted(input logic rd, input logic wr,
                        input logic [31:0] addr, input logic [31:0] data, input logic [3:0] ben);
                logic ok;
                int tries;
                ok = 1'b0;
                tries = 0;
                while (!ok && tries < MAX_TRY)
                begin
                        run_cycle(rd, wr, addr, rand_bits(11) << 2, data, ben, 1'b1, 1'b0, ok);
                        tries++;
                end
                assert (ok)
                else
                        note_failure($sformatf("access at %h never granted in %0d tries",
                                               addr, tries));
        endtask

        // Idle cycle that closes a test.
        task automatic finish_test();
                logic ok;
                run_cycle(1'b0, 1'b0, '0, rand_bits(11) << 2, '0, '0, 1'b1, 1'b1, ok);
        endtask

        always @(posedge i_clk)
        begin
                #1;
                if (n_compared < n_driven)
                begin
                        check_value("o_abort", pend.abort, o_abort);
                        check_value("o_miss", pend.miss, o_miss);
                        check_value("o_abort1", pend.abort1, o_abort1);
                        check_value("o_hit1", pend.hit1, o_hit1);
                        check_value("o_data", pend.data, o_data);
                        check_value("o_data1", pend.data1, o_data1);
                        if (pend_last)
                        begin
                                $display("Test %0d (%s) done, %0d errors", pend_test, pend_name,
                                         test_err);
                                test_err = 0;
                        end
                        n_compared++;
                end
        end

        initial
        begin
                logic ok;
                logic [31:0] a;
                logic [31:0] d;
                int tries;
                $timeformat(-9, 0, " ns", 0);
                for (int i = 0; i < mem_pkg::MEM_BYTES; i++)
                        ref_mem[i] = 8'd0;
                repeat (3) @(posedge i_clk);
                #2;
                i_rst_n = 1'b1;
                repeat (2048) @(posedge i_clk);         // Memory clear sweep.

                cur_test = 1;
                cur_name = "miss and hit pattern";
                repeat (64)
                        run_cycle(1'b0, 1'b0, '0, rand_bits(11) << 2, '0, '0, 1'b1, 1'b0, ok);
                finish_test();

                cur_test = 2;
                cur_name = "byte lane writes";
                for (int i = 0; i < N_WR; i++)
                begin
                        wr_addr[i] = rand_data_addr();
                        access_until_granted(1'b0, 1'b1, wr_addr[i], rand_bits(32), rand_bits(4));
                end
                for (int i = 0; i < N_WR; i++)
                        access_until_granted(1'b1, 1'b0, wr_addr[i], '0, '0);
                finish_test();

                cur_test = 3;
                cur_name = "fetch of written words";
                for (int i = 0; i < N_WR; i++)
                        run_cycle(1'b0, 1'b0, '0, wr_addr[i], '0, '0, 1'b1, 1'b0, ok);
                finish_test();

                cur_test = 4;
                cur_name = "range and privilege aborts";
                for (int i = 0; i < N_AB; i++)
                begin
                        if (i % 2 == 0)
                                a = 32'(mem_pkg::MEM_BYTES - 3) + i / 2 % 3;
                        else
                                a = rand_bits(32) | 32'h0000_2000;      // Far past the end.
                        run_cycle(i % 2 == 0, i % 2 == 1, a, a, rand_bits(32), 4'hF, 1'b1,
                                  1'b0, ok);
                        a = rand_bits(10);
                        d = rand_bits(32);
                        access_until_granted(1'b0, 1'b1, a, d, 4'hF);
                        // User mode overwrite must bounce.
                        run_cycle(1'b0, 1'b1, a, rand_bits(11) << 2, ~d, 4'hF,
                                  access_pkg::MODE_USER, 1'b0, ok);
                        access_until_granted(1'b1, 1'b0, a, '0, '0);
                        // User mode above the protected region is allowed.
                        run_cycle(1'b1, 1'b0, wr_addr[i], rand_bits(11) << 2, '0, '0,
                                  access_pkg::MODE_USER, 1'b0, ok);
                end
                finish_test();

                cur_test = 5;
                cur_name = "missed writes and idle cycles";
                for (int i = 0; i < N_AB; i++)
                begin
                        tries = 0;
                        while (!ref_lfsr[access_pkg::MISS_BIT] && tries < MAX_TRY)
                        begin
                                run_cycle(1'b0, 1'b0, '0, rand_bits(11) << 2, '0, '0, 1'b1,
                                          1'b0, ok);
                                tries++;
                        end
                        a = wr_addr[i];
                        run_cycle(1'b0, 1'b1, a, rand_bits(11) << 2, rand_bits(32), 4'hF, 1'b1,
                                  1'b0, ok);
                        assert (!ok)
                        else
                                note_failure($sformatf("write at %h was granted, a miss was due",
                                                       a));
                        access_until_granted(1'b1, 1'b0, a, '0, '0);
                end
                finish_test();

                wait (n_compared == n_driven);
                $display("Done: %0d cycles compared, %0d errors", n_compared, err_count);
                if (err_count == 0)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

`default_nettype wire

/* files.f */
verilog/mem_pkg.sv
verilog/access_pkg.sv
verilog/mem_port_if.sv
verilog/access_checker.sv
verilog/byte_lane_ram.sv
verilog/read_merge.sv
verilog/cache_top.sv
dv/tb_cache_top.sv

/* verilog/access_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module access_checker
(
        input  logic                    i_clk,
        input  logic                    i_rst_n,
        input  logic [31:0]             i_address,
        input  logic [31:0]             i_address1,
        input  logic [31:0]             i_data,
        input  mem_pkg::ben_t           i_ben,
        input  logic                    i_cpsr,
        input  logic                    i_rd_en,
        input  logic                    i_wr_en,
        input  logic                    i_init_done,
        output logic [1:0]              o_data_dec,     // {abort, miss}.
        output logic [1:0]              o_fetch_dec,    // {abort1, hit1}.
        mem_port_if.req                 data_port,
        mem_port_if.req                 fetch_port
);

        logic [access_pkg::LFSR_W-1:0]  lfsr_q;
        logic                           data_req;
        logic                           range_err;
        logic                           priv_err;
        logic                           abort;
        logic                           miss;
        logic                           abort1;
        logic                           hit1;

        // Miss source. Frozen during the clear sweep.
        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                        lfsr_q <= access_pkg::LFSR_SEED;
                else if (i_init_done)
                        lfsr_q <= (lfsr_q >> 1) ^
                                  ({access_pkg::LFSR_W{lfsr_q[0]}} & access_pkg::LFSR_TAPS);
        end

        assign data_req = i_rd_en || i_wr_en;

        // Last byte of the word must lie inside memory.
        assign range_err = ({1'b0, i_address} + 33'd3) >= 33'(mem_pkg::MEM_BYTES);
        assign priv_err  = (i_cpsr == access_pkg::MODE_USER) &&
                           (i_address < 32'(access_pkg::PROT_LIMIT));

        // No abort while memory is still being cleared, only a miss.
        assign abort = data_req && i_init_done && (range_err || priv_err);
        assign miss  = !abort && (!i_init_done || lfsr_q[access_pkg::MISS_BIT]);

        assign abort1 = ({1'b0, i_address1} + 33'd3) >= 33'(mem_pkg::MEM_BYTES);
        assign hit1   = i_init_done && !abort1 && lfsr_q[access_pkg::HIT_BIT];

        assign o_data_dec  = {abort, miss};
        assign o_fetch_dec = {abort1, hit1};

        // Only granted accesses reach the RAM.
        assign data_port.en    = data_req && !abort && !miss;
        assign data_port.we    = i_wr_en;
        assign data_port.addr  = i_address[mem_pkg::ADDR_W-1:0];
        assign data_port.ben   = i_ben;
        assign data_port.wdata = i_data;

        // Fetch port is read only.
        assign fetch_port.en    = hit1;
        assign fetch_port.we    = 1'b0;
        assign fetch_port.addr  = i_address1[mem_pkg::ADDR_W-1:0];
        assign fetch_port.ben   = '0;
        assign fetch_port.wdata = '0;

        // A request that aborts must never touch memory.
        a_no_abort_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !(data_port.en && o_data_dec[1]));

endmodule

`default_nettype wire

/* verilog/access_pkg.sv */
`default_nettype none

package access_pkg;

        // Value of i_cpsr in user mode.
        localparam logic MODE_USER = 1'b0;

        // Data addresses below this are privileged.
        localparam int PROT_LIMIT = 1024;

        // Miss emulation LFSR.
        localparam int LFSR_W = 16;
        localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;

        // Right-shifting Galois taps.
        localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

        localparam int MISS_BIT = 0;    // State bit marking a data miss.
        localparam int HIT_BIT  = 1;    // State bit marking a fetch hit.

endpackage

`default_nettype wire

/* verilog/byte_lane_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram
(
        input  logic            i_clk,
        input  logic            i_rst_n,
        mem_port_if.mem         data_port,
        mem_port_if.mem         fetch_port,
        output logic            o_init_done
);

        logic [7:0]                     byte_mem [mem_pkg::MEM_BYTES];
        logic [mem_pkg::ADDR_W-3:0]     init_cnt;
        logic                           wr;
        mem_pkg::word_t                 data_word;
        mem_pkg::word_t                 fetch_word;

        // Stored byte replaced by a lane of this cycle's write that hits the address.
        function automatic logic [7:0] fwd_byte
        (
                input logic [mem_pkg::ADDR_W-1:0]       a,
                input logic [7:0]                       stored,
                input logic                             wen,
                input logic [mem_pkg::ADDR_W-1:0]       wa,
                input mem_pkg::ben_t                    ben,
                input mem_pkg::word_t                   wd
        );
                logic [7:0] b;

                b = stored;
                for (int m = 0; m < mem_pkg::BEN_W; m++)
                begin
                        if (wen && ben[m] && ((wa + mem_pkg::ADDR_W'(m)) == a))
                                b = wd[8*m +: 8];
                end
                return b;
        endfunction

        assign wr = data_port.en && data_port.we;

        // Clear sweep of one word per cycle.
        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                begin
                        init_cnt    <= '0;
                        o_init_done <= 1'b0;
                end
                else if (!o_init_done)
                begin
                        init_cnt <= init_cnt + 1'b1;
                        if (&init_cnt)
                                o_init_done <= 1'b1;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (!o_init_done)
                begin
                        for (int n = 0; n < mem_pkg::BEN_W; n++)
                                byte_mem[{init_cnt, 2'(n)}] <= 8'd0;
                end
                else if (wr)
                begin
                        for (int n = 0; n < mem_pkg::BEN_W; n++)
                        begin
                                if (data_port.ben[n])
                                        byte_mem[data_port.addr + mem_pkg::ADDR_W'(n)] <=
                                                data_port.wdata[8*n +: 8];
                        end
                end
        end

        // Little-endian assembly. Both ports see the write bytes.
        always_comb
        begin
                for (int n = 0; n < mem_pkg::BEN_W; n++)
                begin
                        data_word[8*n +: 8] = fwd_byte(data_port.addr + mem_pkg::ADDR_W'(n),
                                byte_mem[data_port.addr + mem_pkg::ADDR_W'(n)],
                                wr, data_port.addr, data_port.ben, data_port.wdata);
                        fetch_word[8*n +: 8] = fwd_byte(fetch_port.addr + mem_pkg::ADDR_W'(n),
                                byte_mem[fetch_port.addr + mem_pkg::ADDR_W'(n)],
                                wr, data_port.addr, data_port.ben, data_port.wdata);
                end
        end

        // Zero when idle.
        always_ff @(posedge i_clk)
        begin
                data_port.rdata  <= data_port.en ? data_word : '0;
                fetch_port.rdata <= fetch_port.en ? fetch_word : '0;
        end

        a_no_access_in_sweep: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !o_init_done |-> !(data_port.en || fetch_port.en));

endmodule

`default_nettype wire

/* verilog/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top
(
        input  logic            i_clk,
        input  logic            i_rst_n,
        input  logic [31:0]     i_address,      // Data address.
        input  logic [31:0]     i_address1,     // Fetch address.
        input  logic [31:0]     i_data,
        input  logic [3:0]      i_ben,
        input  logic            i_cpsr,
        input  logic            i_rd_en,
        input  logic            i_wr_en,
        output logic [31:0]     o_data,
        output logic [31:0]     o_data1,
        output logic            o_miss,
        output logic            o_hit1,
        output logic            o_abort,
        output logic            o_abort1
);

        logic [1:0]     data_dec;
        logic [1:0]     fetch_dec;
        logic           init_done;

        mem_port_if data_port ();
        mem_port_if fetch_port ();

        // Decides abort and miss, drives both ports.
        access_checker u_access_checker
        (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_address      (i_address),
                .i_address1     (i_address1),
                .i_data         (i_data),
                .i_ben          (i_ben),
                .i_cpsr         (i_cpsr),
                .i_rd_en        (i_rd_en),
                .i_wr_en        (i_wr_en),
                .i_init_done    (init_done),
                .o_data_dec     (data_dec),
                .o_fetch_dec    (fetch_dec),
                .data_port      (data_port.req),
                .fetch_port     (fetch_port.req)
        );

        byte_lane_ram u_byte_lane_ram
        (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .data_port      (data_port.mem),
                .fetch_port     (fetch_port.mem),
                .o_init_done    (init_done)
        );

        // Output words and flags.
        read_merge u_read_merge
        (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_data_dec     (data_dec),
                .i_fetch_dec    (fetch_dec),
                .data_port      (data_port.view),
                .fetch_port     (fetch_port.view),
                .o_data         (o_data),
                .o_data1        (o_data1),
                .o_miss         (o_miss),
                .o_hit1         (o_hit1),
                .o_abort        (o_abort),
                .o_abort1       (o_abort1)
        );

endmodule

`default_nettype wire

/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

        // Storage size in bytes.
        localparam int MEM_BYTES = 8192;

        // Byte address inside the array.
        localparam int ADDR_W = 13;

        localparam int WORD_W = 32;     // Data word width.
        localparam int BEN_W  = 4;      // One enable per byte lane.

        // Lane n holds bits 8n+7 down to 8n.
        typedef logic [WORD_W-1:0] word_t;
        typedef logic [BEN_W-1:0]  ben_t;

endpackage

`default_nettype wire

/* verilog/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;

        logic                           en;     // Granted access.
        logic                           we;
        logic [mem_pkg::ADDR_W-1:0]     addr;
        mem_pkg::ben_t                  ben;
        mem_pkg::word_t                 wdata;
        mem_pkg::word_t                 rdata;  // Registered read word.

        // Request side.
        modport req
        (
                output en, we, addr, ben, wdata,
                input  rdata
        );

        // RAM side.
        modport mem
        (
                input  en, we, addr, ben, wdata,
                output rdata
        );

        // Result side only sees the read word.
        modport view
        (
                input  rdata
        );

endinterface

`default_nettype wire

/* verilog/read_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module read_merge
(
        input  logic            i_clk,
        input  logic            i_rst_n,
        input  logic [1:0]      i_data_dec,     // {abort, miss}.
        input  logic [1:0]      i_fetch_dec,    // {abort1, hit1}.
        mem_port_if.view        data_port,
        mem_port_if.view        fetch_port,
        output mem_pkg::word_t  o_data,
        output mem_pkg::word_t  o_data1,
        output logic            o_miss,
        output logic            o_hit1,
        output logic            o_abort,
        output logic            o_abort1
);

        logic   abort_q;
        logic   miss_q;
        logic   abort1_q;
        logic   hit1_q;

        // Line up the decisions with the RAM read word.
        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                begin
                        abort_q  <= 1'b0;
                        miss_q   <= 1'b0;
                        abort1_q <= 1'b0;
                        hit1_q   <= 1'b0;
                end
                else
                begin
                        abort_q  <= i_data_dec[1];
                        miss_q   <= i_data_dec[0];
                        abort1_q <= i_fetch_dec[1];
                        hit1_q   <= i_fetch_dec[0];
                end
        end

        assign o_data  = (abort_q || miss_q) ? '0 : data_port.rdata;
        assign o_data1 = hit1_q ? fetch_port.rdata : '0;   // Only on a hit.

        assign o_miss   = miss_q;
        assign o_hit1   = hit1_q;
        assign o_abort  = abort_q;
        assign o_abort1 = abort1_q;

        a_abort_excludes_miss: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !(o_abort && o_miss));

endmodule

`default_nettype wire
